// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int xlen    = 32;	// register and data width
	localparam int pc_w    = 22;	// program counter width
	localparam int reg_aw  = 5;	// register number width
	localparam int imm_w   = 17;	// immediate width
	localparam int ret_reg = 29;	// jr through this one returns via the return register

	// instruction fields
	localparam int op_hi     = 31;
	localparam int op_lo     = 27;
	localparam int pri_lo    = 22;	// primary register, also dst
	localparam int pri_hi    = pri_lo + reg_aw - 1;
	localparam int src_lo    = 17;
	localparam int src_hi    = src_lo + reg_aw - 1;
	localparam int src2_lo   = 12;
	localparam int src2_hi   = src2_lo + reg_aw - 1;
	localparam int alt_lo    = 10;	// act/ld source, rd/cord dst
	localparam int alt_hi    = alt_lo + reg_aw - 1;
	localparam int imm_lo    = 0;
	localparam int imm_hi    = imm_lo + imm_w - 1;
	localparam int label_hi  = pc_w - 1;	// branch/jal label reaches into the src field
	localparam int cond_hi   = 26;
	localparam int cond_lo   = 24;
	// sprite fields overlap the register fields
	localparam int spr_act_hi  = 26;
	localparam int spr_act_lo  = 23;
	localparam int spr_addr_hi = 22;
	localparam int spr_addr_lo = 15;
	localparam int spr_imm_hi  = 14;
	localparam int spr_imm_lo  = 1;
	localparam int spr_use_imm = 0;

	typedef enum logic [4:0] {
		add    = 5'b00000, addi = 5'b00001, sub  = 5'b00010, subi   = 5'b00011,
		lw     = 5'b00100, sw   = 5'b00101, mov  = 5'b00110, movi   = 5'b00111,
		and_op = 5'b01000, or_op = 5'b01001, nor_op = 5'b01010, sll = 5'b01011,
		srl    = 5'b01100, sra  = 5'b01101, br   = 5'b01110,
		jr     = 5'b10000, jal  = 5'b10001, act  = 5'b10010, ld     = 5'b10011,
		rd     = 5'b10100, map  = 5'b10101, cord = 5'b10110, key    = 5'b10111,
		tm     = 5'b11000, halt = 5'b11111
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_nor, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    use_dst;	// writeback enable
		logic    upd_neg;
		logic    upd_carry;
		logic    upd_ovf;
		logic    upd_zero;
		logic    mem_re;
		logic    mem_we;
		logic    mem_to_reg;
		logic    sprite_re;
		logic    sprite_we;
		logic    sprite_to_reg;
		logic    use_sprite_mem;
		logic    io_re;	// spart / keyboard read
		logic    is_branch;
		logic    is_jr;
		logic    is_jal;
	} ctrl_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [pc_w-1:0]   pc;
		logic [pc_w-1:0]   imm_label;	// execute uses the low imm_w bits
		logic [reg_aw-1:0] dst;
		logic [2:0]        branch_cond;
		logic [7:0]        sprite_addr;
		logic [3:0]        sprite_action;
		logic              sprite_use_imm;
		logic [13:0]       sprite_imm;
		logic              valid;
	} id_ex_t;

endpackage

`default_nettype wire

// ==== logic/decode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl
	import cpu_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              instr_valid,
	input  wire logic              stall,
	input  wire opcode_e           opcode,
	input  wire logic [reg_aw-1:0] dst,
	output ctrl_t                  ctrl,
	output logic                   is_mov,
	output logic                   is_movi,
	output logic                   is_act_ld,
	output logic                   is_rd_cord,
	output logic                   is_sw,
	output logic                   halted
);

	logic accept;

	assign accept = instr_valid && !stall;

	always_comb begin
		ctrl       = '0;	// alu_add, all strobes off
		is_mov     = 1'b0;
		is_movi    = 1'b0;
		is_act_ld  = 1'b0;
		is_rd_cord = 1'b0;
		is_sw      = 1'b0;
		case (opcode)
			add, addi, sub, subi: begin
				ctrl.alu_op    = (opcode == sub || opcode == subi) ? alu_sub : alu_add;
				ctrl.use_imm   = (opcode == addi || opcode == subi);
				// add to r0 is the nop form, no writeback
				ctrl.use_dst   = (opcode != add) || (dst != '0);
				ctrl.upd_neg   = 1'b1;
				ctrl.upd_carry = 1'b1;
				ctrl.upd_ovf   = 1'b1;
				ctrl.upd_zero  = 1'b1;
			end
			lw: begin
				ctrl.mem_re     = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.use_dst    = 1'b1;
			end
			sw: begin
				ctrl.use_imm = 1'b1;	// base + offset
				ctrl.mem_we  = 1'b1;
				is_sw        = 1'b1;
			end
			mov: begin
				ctrl.use_dst = 1'b1;
				is_mov       = 1'b1;	// rs + r0
			end
			movi: begin
				ctrl.use_dst = 1'b1;
				ctrl.use_imm = 1'b1;
				is_movi      = 1'b1;	// behaves as addi from r0
			end
			and_op, or_op, nor_op: begin
				ctrl.alu_op   = (opcode == and_op) ? alu_and :
				                (opcode == or_op)  ? alu_or  : alu_nor;
				ctrl.use_dst  = 1'b1;
				ctrl.upd_zero = 1'b1;
			end
			sll, srl, sra: begin
				ctrl.alu_op   = (opcode == sll) ? alu_sll :
				                (opcode == srl) ? alu_srl : alu_sra;
				ctrl.use_dst  = 1'b1;
				ctrl.use_imm  = 1'b1;	// shift amount
				ctrl.upd_zero = 1'b1;
				ctrl.upd_ovf  = (opcode == sll);	// bits shifted out on the left
			end
			br: begin
				ctrl.use_imm   = 1'b1;
				ctrl.is_branch = 1'b1;
			end
			jr: begin
				ctrl.is_jr     = 1'b1;
				ctrl.is_branch = 1'b1;
			end
			jal: begin
				ctrl.use_imm   = 1'b1;
				ctrl.is_jal    = 1'b1;
				ctrl.is_branch = 1'b1;
			end
			act, ld: begin
				ctrl.sprite_we = 1'b1;
				is_act_ld      = 1'b1;
			end
			rd, cord: begin
				ctrl.sprite_re      = 1'b1;
				ctrl.sprite_to_reg  = 1'b1;
				ctrl.use_sprite_mem = 1'b1;
				is_rd_cord          = 1'b1;
			end
			map, tm: ctrl.sprite_we = 1'b1;
			key:     ctrl.io_re     = 1'b1;
			default: ;	// halt and unused codes decode to nothing
		endcase
	end

	// sticky, only reset clears it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			halted <= 1'b0;
		else if (accept && opcode == halt)
			halted <= 1'b1;
	end

	a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.mem_re && ctrl.mem_we));

	a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted);

endmodule

`default_nettype wire

// ==== logic/reg_addr_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_addr_sel
	import cpu_pkg::*;
(
	input  wire logic [xlen-1:0]   instr,
	input  wire logic              is_mov,
	input  wire logic              is_movi,
	input  wire logic              is_act_ld,
	input  wire logic              is_rd_cord,
	input  wire logic              is_jr,
	input  wire logic              is_sw,
	input  wire logic              halt_read,
	input  wire logic              halted,
	input  wire logic [reg_aw-1:0] halt_addr,
	output logic      [reg_aw-1:0] rs_addr,
	output logic      [reg_aw-1:0] rt_addr,
	output logic      [reg_aw-1:0] dst
);

	// debug dump takes the source port over
	assign rs_addr = (halt_read || halted) ? halt_addr :
	                 is_movi               ? '0 :
	                 is_act_ld             ? instr[alt_hi:alt_lo] :
	                 is_jr                 ? instr[pri_hi:pri_lo] :
	                                         instr[src_hi:src_lo];

	assign rt_addr = is_mov ? '0 :
	                 is_sw  ? instr[pri_hi:pri_lo] :	// store data register
	                          instr[src2_hi:src2_lo];

	assign dst = is_rd_cord ? instr[alt_hi:alt_lo] : instr[pri_hi:pri_lo];

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import cpu_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              rd_en,
	input  wire logic [reg_aw-1:0] rs_addr,
	input  wire logic [reg_aw-1:0] rt_addr,
	output logic      [xlen-1:0]   rs_data,
	output logic      [xlen-1:0]   rt_data,
	input  wire logic              wb_we,
	input  wire logic [reg_aw-1:0] wb_addr,
	input  wire logic [xlen-1:0]   wb_data
);

	logic [xlen-1:0] regs [2**reg_aw];	// entry 0 never written

	// read with write-first bypass from writeback
	function automatic logic [xlen-1:0] rd_val(input logic [reg_aw-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wb_we && wb_addr == addr)
			return wb_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**reg_aw; i++)
				regs[i] <= '0;
		end else if (wb_we && wb_addr != '0) begin
			regs[wb_addr] <= wb_data;	// never stalled
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rs_data <= '0;
			rt_data <= '0;
		end else if (rd_en) begin
			rs_data <= rd_val(rs_addr);
			rt_data <= rd_val(rt_addr);
		end
	end

endmodule

`default_nettype wire

// ==== logic/branch_target.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_target
	import cpu_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              jal_take,
	input  wire logic [pc_w-1:0]   next_pc,
	input  wire id_ex_t            ex,
	input  wire logic [reg_aw-1:0] jr_reg,
	input  wire logic [xlen-1:0]   rs_data,
	output logic      [pc_w-1:0]   target
);

	logic [pc_w-1:0] ret_addr;	// link register, kept outside the register file
	logic            jr_ret;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ret_addr <= '0;
		else if (jal_take)
			ret_addr <= next_pc;
	end

	assign jr_ret = ex.ctrl.is_jr && (jr_reg == reg_aw'(ret_reg));

	always_comb begin
		if (jr_ret)
			target = ret_addr;	// return from jal
		else if (ex.ctrl.is_jr)
			target = rs_data[pc_w-1:0];
		else
			target = ex.imm_label;	// b / jal label
	end

endmodule

`default_nettype wire

// ==== logic/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
	import cpu_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              stall,
	input  wire logic              in_valid,
	input  wire id_ex_t            d,
	output id_ex_t                 q,
	output logic      [reg_aw-1:0] jr_reg
);

	id_ex_t q_nxt;

	always_comb begin
		q_nxt       = d;
		q_nxt.valid = in_valid;
		if (!in_valid)
			q_nxt.ctrl = '0;	// a bubble carries no enables into execute
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q      <= '0;
			jr_reg <= '0;
		end else if (!stall) begin
			q      <= q_nxt;
			// jr never takes the alternate dst, so dst is the primary field here
			jr_reg <= d.dst;
		end
	end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(q));

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
	import cpu_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic [xlen-1:0]   instr,
	input  wire logic              instr_valid,
	input  wire logic [pc_w-1:0]   pc,
	input  wire logic [pc_w-1:0]   next_pc,
	input  wire logic              stall,
	input  wire logic              wb_we,
	input  wire logic [reg_aw-1:0] wb_addr,
	input  wire logic [xlen-1:0]   wb_data,
	input  wire logic              halt_read,
	input  wire logic [reg_aw-1:0] halt_addr,
	output id_ex_t                 ex,
	output logic      [xlen-1:0]   rs_data,
	output logic      [xlen-1:0]   rt_data,
	output logic      [pc_w-1:0]   branch_target,
	output logic                   halted
);

	opcode_e           opcode;
	ctrl_t             ctrl;
	id_ex_t            id;
	logic              is_mov, is_movi, is_act_ld, is_rd_cord, is_sw;
	logic [reg_aw-1:0] rs_addr, rt_addr, dst, jr_reg;
	logic              jal_take, rd_en;

	assign opcode   = opcode_e'(instr[op_hi:op_lo]);
	assign jal_take = instr_valid && !stall && ctrl.is_jal;
	assign rd_en    = !stall || halt_read || halted;	// debug reads ignore stall

	always_comb begin
		id                = '0;
		id.ctrl           = ctrl;
		id.pc             = pc;
		// label is the immediate extended with bits 21:17
		id.imm_label      = {instr[label_hi:imm_hi+1], instr[imm_hi:imm_lo]};
		id.dst            = dst;
		id.branch_cond    = instr[cond_hi:cond_lo];
		id.sprite_addr    = instr[spr_addr_hi:spr_addr_lo];
		id.sprite_action  = instr[spr_act_hi:spr_act_lo];
		id.sprite_use_imm = instr[spr_use_imm];
		id.sprite_imm     = instr[spr_imm_hi:spr_imm_lo];
		id.valid          = instr_valid;
	end

	decode_ctrl u_ctrl (
		.clk, .rst_n, .instr_valid, .stall, .opcode, .dst, .ctrl,
		.is_mov, .is_movi, .is_act_ld, .is_rd_cord, .is_sw, .halted
	);

	reg_addr_sel u_sel (
		.instr, .is_mov, .is_movi, .is_act_ld, .is_rd_cord, .is_jr(ctrl.is_jr),
		.is_sw, .halt_read, .halted, .halt_addr, .rs_addr, .rt_addr, .dst
	);

	reg_file u_rf (
		.clk, .rst_n, .rd_en, .rs_addr, .rt_addr, .rs_data, .rt_data,
		.wb_we, .wb_addr, .wb_data
	);

	id_ex_reg u_id_ex (
		.clk, .rst_n, .stall, .in_valid(instr_valid), .d(id), .q(ex), .jr_reg
	);

	branch_target u_bt (
		.clk, .rst_n, .jal_take, .next_pc, .ex, .jr_reg, .rs_data, .target(branch_target)
	);

endmodule

`default_nettype wire

// ==== testbench/decode_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_checker
	import cpu_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic [xlen-1:0]   instr,
	input  wire logic              instr_valid,
	input  wire logic [pc_w-1:0]   pc,
	input  wire logic [pc_w-1:0]   next_pc,
	input  wire logic              stall,
	input  wire logic              wb_we,
	input  wire logic [reg_aw-1:0] wb_addr,
	input  wire logic [xlen-1:0]   wb_data,
	input  wire logic              halt_read,
	input  wire logic [reg_aw-1:0] halt_addr,
	input  wire id_ex_t            ex,
	input  wire logic [xlen-1:0]   rs_data,
	input  wire logic [xlen-1:0]   rt_data,
	input  wire logic [pc_w-1:0]   branch_target,
	input  wire logic              halted,
	input  wire logic              finish_run,
	output int                     errors,
	output int                     checks
);

	logic [xlen-1:0]   shadow [32];	// reference register file
	id_ex_t            exp_ex;
	logic [xlen-1:0]   exp_rs, exp_rt;
	logic [reg_aw-1:0] exp_jr_reg;
	logic [pc_w-1:0]   ret_model;	// link value from the last accepted jal
	logic              halted_model;
	int                accepted;

	// control table, one line per signal
	function automatic ctrl_t ref_ctrl(input opcode_e op, input logic [reg_aw-1:0] d);
		ctrl_t c;
		logic  arith;
		c     = '0;
		arith = op inside {add, addi, sub, subi};
		case (op)
			sub, subi: c.alu_op = alu_sub;
			and_op:    c.alu_op = alu_and;
			or_op:     c.alu_op = alu_or;
			nor_op:    c.alu_op = alu_nor;
			sll:       c.alu_op = alu_sll;
			srl:       c.alu_op = alu_srl;
			sra:       c.alu_op = alu_sra;
			default:   c.alu_op = alu_add;
		endcase
		c.use_imm        = op inside {addi, subi, sw, movi, sll, srl, sra, br, jal};
		// add into r0 writes nothing
		c.use_dst        = (arith && !(op == add && d == '0)) ||
		                   op inside {lw, mov, movi, and_op, or_op, nor_op, sll, srl, sra};
		c.upd_neg        = arith;
		c.upd_carry      = arith;
		c.upd_ovf        = arith || op == sll;
		c.upd_zero       = arith || op inside {and_op, or_op, nor_op, sll, srl, sra};
		c.mem_re         = op == lw;
		c.mem_we         = op == sw;
		c.mem_to_reg     = op == lw;
		c.sprite_we      = op inside {act, ld, map, tm};
		c.sprite_re      = op inside {rd, cord};
		c.sprite_to_reg  = c.sprite_re;
		c.use_sprite_mem = c.sprite_re;
		c.io_re          = op == key;	// keyboard
		c.is_branch      = op inside {br, jr, jal};
		c.is_jr          = op == jr;
		c.is_jal         = op == jal;
		return c;
	endfunction

	// writeback of the same edge wins
	function automatic logic [xlen-1:0] shadow_read(input logic [reg_aw-1:0] a);
		if (a == '0)
			return '0;
		if (wb_we && wb_addr == a)
			return wb_data;
		return shadow[a];
	endfunction

	always @(posedge clk or negedge rst_n) begin : model
		opcode_e           op;
		logic [reg_aw-1:0] ra, rb, d;
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				shadow[i] = '0;
			exp_ex       = '0;
			exp_rs       = '0;
			exp_rt       = '0;
			exp_jr_reg   = '0;
			ret_model    = '0;
			halted_model = 1'b0;
		end else begin
			op = opcode_e'(instr[op_hi:op_lo]);
			d  = (op inside {rd, cord}) ? instr[alt_hi:alt_lo] : instr[pri_hi:pri_lo];
			if (!stall) begin	// id/ex moves
				exp_ex.ctrl           = instr_valid ? ref_ctrl(op, d) : '0;
				exp_ex.pc             = pc;
				exp_ex.imm_label      = instr[pc_w-1:0];
				exp_ex.dst            = d;
				exp_ex.branch_cond    = instr[26:24];
				exp_ex.sprite_addr    = instr[spr_addr_hi:spr_addr_lo];
				exp_ex.sprite_action  = instr[spr_act_hi:spr_act_lo];
				exp_ex.sprite_use_imm = instr[spr_use_imm];
				exp_ex.sprite_imm     = instr[spr_imm_hi:spr_imm_lo];
				exp_ex.valid          = instr_valid;
				exp_jr_reg            = instr[pri_hi:pri_lo];
			end
			if (!stall || halt_read || halted_model) begin
				if (halt_read || halted_model)
					ra = halt_addr;	// debug dump
				else if (op == movi)
					ra = '0;
				else if (op inside {act, ld})
					ra = instr[alt_hi:alt_lo];
				else if (op == jr)
					ra = instr[pri_hi:pri_lo];
				else
					ra = instr[src_hi:src_lo];
				rb = (op == mov) ? '0 :
				     (op == sw)  ? instr[pri_hi:pri_lo] : instr[src2_hi:src2_lo];
				exp_rs = shadow_read(ra);
				exp_rt = shadow_read(rb);
			end
			if (instr_valid && !stall) begin
				accepted++;
				if (op == jal)
					ret_model = next_pc;
				if (op == halt)
					halted_model = 1'b1;
			end
			if (wb_we && wb_addr != '0)
				shadow[wb_addr] = wb_data;
		end
	end

	task automatic check_val(input string name, input logic [127:0] got,
	                         input logic [127:0] want);
		if (got !== want) begin
			errors++;
			$display("[FAIL] %s got %0h expected %0h at %0t", name, got, want, $time);
		end
	endtask

	// outputs settle after the rising edge, compared half a cycle later
	always @(negedge clk) begin : compare
		logic [pc_w-1:0] exp_tgt;
		if (exp_ex.ctrl.is_jr && exp_jr_reg == reg_aw'(ret_reg))
			exp_tgt = ret_model;
		else if (exp_ex.ctrl.is_jr)
			exp_tgt = exp_rs[pc_w-1:0];
		else
			exp_tgt = exp_ex.imm_label;
		if (rst_n) begin
			checks++;
			check_val("ex.ctrl", 128'(ex.ctrl), 128'(exp_ex.ctrl));
			check_val("ex.dst", 128'(ex.dst), 128'(exp_ex.dst));
			check_val("ex", 128'(ex), 128'(exp_ex));
			check_val("rs_data", 128'(rs_data), 128'(exp_rs));
			check_val("rt_data", 128'(rt_data), 128'(exp_rt));
			check_val("branch_target", 128'(branch_target), 128'(exp_tgt));
			check_val("halted", 128'(halted), 128'(halted_model));
		end
	end

	always @(posedge finish_run)
		$display("decode_checker: %0d accepted, %0d cycles checked, %0d errors",
		         accepted, checks, errors);

endmodule

`default_nettype wire

// ==== testbench/tb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode
	import cpu_pkg::*;
();

	localparam int n_instr    = 2000;
	localparam int max_cycles = n_instr * 2 + 100;	// stall and bubbles stay well under half

	logic              clk;
	logic              rst_n;
	logic [xlen-1:0]   instr;
	logic              instr_valid;
	logic [pc_w-1:0]   pc, next_pc;
	logic              stall;
	logic              wb_we;
	logic [reg_aw-1:0] wb_addr;
	logic [xlen-1:0]   wb_data;
	logic              halt_read;
	logic [reg_aw-1:0] halt_addr;
	id_ex_t            ex;
	logic [xlen-1:0]   rs_data, rt_data;
	logic [pc_w-1:0]   branch_target;
	logic              halted;
	logic              finish_run;
	int                errors, checks;
	int                cycles;
	int                accepted;

	opcode_e ops [24] = '{add, addi, sub, subi, lw, sw, mov, movi, and_op, or_op, nor_op,
	                      sll, srl, sra, br, jr, jal, act, ld, rd, map, cord, key, tm};

	decode_stage dut (
		.clk, .rst_n, .instr, .instr_valid, .pc, .next_pc, .stall, .wb_we, .wb_addr,
		.wb_data, .halt_read, .halt_addr, .ex, .rs_data, .rt_data, .branch_target, .halted
	);

	decode_checker chk (
		.clk, .rst_n, .instr, .instr_valid, .pc, .next_pc, .stall, .wb_we, .wb_addr,
		.wb_data, .halt_read, .halt_addr, .ex, .rs_data, .rt_data, .branch_target, .halted,
		.finish_run, .errors, .checks
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout, run still going after %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// extra weight on jumps, half the jr go through r29
	function automatic logic [xlen-1:0] make_instr();
		logic [xlen-1:0] w;
		opcode_e         op;
		w  = $urandom;
		op = (($urandom % 4) == 0) ? ((($urandom % 2) == 0) ? jal : jr) : ops[$urandom % 24];
		w[op_hi:op_lo] = op;
		if (op == jr && ($urandom % 2) == 0)
			w[pri_hi:pri_lo] = reg_aw'(ret_reg);
		if (op == add && ($urandom % 4) == 0)
			w[pri_hi:pri_lo] = '0;	// nop form
		return w;
	endfunction

	task automatic drive_wb();
		wb_we   = ($urandom % 2) == 0;
		// hit the read address now and then for the bypass
		wb_addr = (($urandom % 4) != 0) ? reg_aw'($urandom) :
		          halt_read ? halt_addr : instr[src_hi:src_lo];
		wb_data = $urandom;
	endtask

	task automatic drive_cycle();
		if (!stall) begin	// last word taken, upstream moves on
			instr       = make_instr();
			instr_valid = ($urandom % 10) != 0;
			pc          = pc_w'($urandom);
			next_pc     = pc + 22'd1;
		end
		stall = ($urandom % 5) == 0;
		// host debug read now and then, before any halt too
		halt_read = ($urandom % 16) == 0;
		halt_addr = reg_aw'($urandom);
		drive_wb();
	endtask

	initial begin
		void'($urandom(32'hb298));
		rst_n       = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		pc          = '0;
		next_pc     = '0;
		stall       = 1'b0;
		wb_we       = 1'b0;
		wb_addr     = '0;
		wb_data     = '0;
		halt_read   = 1'b0;
		halt_addr   = '0;
		finish_run  = 1'b0;
		accepted    = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		while (accepted < n_instr) begin
			drive_cycle();
			@(negedge clk);
			if (instr_valid && !stall)
				accepted++;
		end
		// halt, then dump every register over the debug port
		instr       = {halt, 27'($urandom)};
		instr_valid = 1'b1;
		stall       = 1'b0;
		halt_read   = 1'b0;
		drive_wb();
		@(negedge clk);
		instr_valid = 1'b0;
		halt_read   = 1'b1;
		for (int a = 0; a < 32; a++) begin
			halt_addr = reg_aw'(a);
			stall     = ($urandom % 5) == 0;	// dump reads ignore stall
			drive_wb();
			@(negedge clk);
		end
		#1;
		finish_run = 1'b1;
		#1;
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/cpu_pkg.sv
logic/decode_ctrl.sv
logic/reg_addr_sel.sv
logic/reg_file.sv
logic/branch_target.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_decode \
	|| { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_decode)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "TEST PASSED" && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
